// ==== design/noc_pkg.sv ====
package noc_pkg;

        // width of one mesh coordinate
        // two bits cover meshes up to 4x4
        localparam int COORD_W = 2;

        // source node number width
        localparam int NODE_W = 4;

        // payload width
        localparam int DATA_W = 16;

        // local plus four neighbour links
        localparam int NUM_PORTS = 5;

        // router port index, also used as route request
        typedef enum logic [2:0] {
                PORT_LOCAL = 3'd0,
                PORT_NORTH = 3'd1,
                PORT_EAST  = 3'd2,
                PORT_SOUTH = 3'd3,
                PORT_WEST  = 3'd4
        } port_e;

        // single flit packet
        // destination picks the path, src and payload ride along
        typedef struct packed {
                logic [COORD_W-1:0] dst_x;
                logic [COORD_W-1:0] dst_y;
                logic [NODE_W-1:0]  src;
                logic [DATA_W-1:0]  payload;
        } flit_t;

        // forward half of a link
        // ready runs back as a plain bit
        typedef struct packed {
                logic  valid;
                flit_t flit;
        } link_t;

endpackage

// ==== design/input_port.sv ====
`timescale 1ns/1ps

module input_port
        import noc_pkg::*;
#(
        parameter int X_POS      = 0,
        parameter int Y_POS      = 0,
        parameter int FIFO_DEPTH = 4
) (
        input  logic  clk,
        input  logic  arst_n,
        input  link_t in_link,
        output logic  in_ready,
        output flit_t head,
        output logic  head_valid,
        output port_e route,
        input  logic  pop
);

        localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
        localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

        // own coordinates at coordinate width
        localparam logic [COORD_W-1:0] MY_X = COORD_W'(X_POS);
        localparam logic [COORD_W-1:0] MY_Y = COORD_W'(Y_POS);

        flit_t            mem [FIFO_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             push;
        logic             do_pop;

        // circular wrap, depth need not be a power of two
        function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
                if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                        return '0;
                end
                return ptr + 1'b1;
        endfunction

        // ready only from occupancy, never from valid
        assign in_ready   = (count != CNT_W'(FIFO_DEPTH));
        assign head_valid = (count != '0);
        assign push       = in_link.valid && in_ready;
        // pop on empty ignored
        assign do_pop     = pop && head_valid;
        assign head       = mem[rd_ptr];

        // flit storage
        always_ff @(posedge clk) begin
                if (push) begin
                        mem[wr_ptr] <= in_link.flit;
                end
        end

        // pointers and occupancy
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push) begin
                                wr_ptr <= next_ptr(wr_ptr);
                        end
                        if (do_pop) begin
                                rd_ptr <= next_ptr(rd_ptr);
                        end
                        // push and pop together keep count
                        case ({push, do_pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // xy routing on the head flit
        // x first, then y, row 0 is north
        always_comb begin
                if (head.dst_x > MY_X) begin
                        route = PORT_EAST;
                end else if (head.dst_x < MY_X) begin
                        route = PORT_WEST;
                end else if (head.dst_y > MY_Y) begin
                        route = PORT_SOUTH;
                end else if (head.dst_y < MY_Y) begin
                        route = PORT_NORTH;
                end else begin
                        // arrived
                        route = PORT_LOCAL;
                end
        end

endmodule

// ==== design/port_arbiter.sv ====
`timescale 1ns/1ps

module port_arbiter
        import noc_pkg::*;
(
        input  logic  clk,
        input  logic  arst_n,
        input  logic  req   [NUM_PORTS],
        input  flit_t flits [NUM_PORTS],
        output logic  grant [NUM_PORTS],
        output link_t out_link,
        input  logic  out_ready
);

        // last winner, search starts just after it
        port_e ptr;
        port_e winner;
        logic  found;
        logic  advance;
        logic  valid_q;
        flit_t flit_q;

        // output stage free, or its flit leaves this edge
        assign advance = !valid_q || out_ready;

        // round robin search over the request vector
        always_comb begin
                int idx;
                winner = ptr;
                found  = 1'b0;
                for (int i = 1; i <= NUM_PORTS; i++) begin
                        idx = (int'(ptr) + i) % NUM_PORTS;
                        if (!found && req[idx]) begin
                                winner = port_e'(idx);
                                found  = 1'b1;
                        end
                end
        end

        // one hot grant, doubles as pop for the winning input
        always_comb begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                        grant[i] = advance && found && (winner == port_e'(i));
                end
        end

        // control state of the output stage
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        valid_q <= 1'b0;
                        ptr     <= PORT_WEST;
                end else if (advance) begin
                        valid_q <= found;
                        if (found) begin
                                ptr <= winner;
                        end
                end
        end

        // crossbar mux into the output register
        // held while stalled
        always_ff @(posedge clk) begin
                if (advance && found) begin
                        flit_q <= flits[winner];
                end
        end

        assign out_link = '{valid: valid_q, flit: flit_q};

endmodule

// ==== design/router.sv ====
`timescale 1ns/1ps

module router
        import noc_pkg::*;
#(
        parameter int X_POS      = 0,
        parameter int Y_POS      = 0,
        parameter int FIFO_DEPTH = 4
) (
        input  logic  clk,
        input  logic  arst_n,
        input  link_t in_link   [NUM_PORTS],
        output logic  in_ready  [NUM_PORTS],
        output link_t out_link  [NUM_PORTS],
        input  logic  out_ready [NUM_PORTS]
);

        // per input port
        flit_t head       [NUM_PORTS];
        logic  head_valid [NUM_PORTS];
        port_e route      [NUM_PORTS];
        logic  pop        [NUM_PORTS];

        // indexed [output][input]
        logic  req        [NUM_PORTS][NUM_PORTS];
        logic  grant      [NUM_PORTS][NUM_PORTS];

        // input FIFOs with route compute
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
                input_port #(
                        .X_POS      (X_POS),
                        .Y_POS      (Y_POS),
                        .FIFO_DEPTH (FIFO_DEPTH)
                ) u_in (
                        .clk        (clk),
                        .arst_n     (arst_n),
                        .in_link    (in_link[i]),
                        .in_ready   (in_ready[i]),
                        .head       (head[i]),
                        .head_valid (head_valid[i]),
                        .route      (route[i]),
                        .pop        (pop[i])
                );
        end

        // each head requests exactly the output its route names
        always_comb begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                req[o][i] = head_valid[i] && (route[i] == port_e'(o));
                        end
                end
        end

        // grants back to inputs
        // at most one output grants a given input
        always_comb begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                        pop[i] = 1'b0;
                        for (int o = 0; o < NUM_PORTS; o++) begin
                                pop[i] = pop[i] | grant[o][i];
                        end
                end
        end

        // one arbiter per output
        // all five heads go to each, the arbiter mux is the crossbar
        for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
                port_arbiter u_arb (
                        .clk       (clk),
                        .arst_n    (arst_n),
                        .req       (req[o]),
                        .flits     (head),
                        .grant     (grant[o]),
                        .out_link  (out_link[o]),
                        .out_ready (out_ready[o])
                );
        end

endmodule

// ==== design/noc_mesh.sv ====
`timescale 1ns/1ps

module noc_mesh
        import noc_pkg::*;
#(
        parameter int MESH_X     = 3,
        parameter int MESH_Y     = 3,
        parameter int FIFO_DEPTH = 4
) (
        input  logic  clk,
        input  logic  arst_n,
        input  link_t inj       [MESH_X*MESH_Y],
        output logic  inj_ready [MESH_X*MESH_Y],
        output link_t ej        [MESH_X*MESH_Y],
        input  logic  ej_ready  [MESH_X*MESH_Y]
);

        localparam int NODES = MESH_X * MESH_Y;

        // router side of every port, [node][port]
        link_t r_in        [NODES][NUM_PORTS];
        logic  r_in_ready  [NODES][NUM_PORTS];
        link_t r_out       [NODES][NUM_PORTS];
        logic  r_out_ready [NODES][NUM_PORTS];

        // node n sits at x = n % MESH_X, y = n / MESH_X
        for (genvar y = 0; y < MESH_Y; y++) begin : g_row
                for (genvar x = 0; x < MESH_X; x++) begin : g_col
                        localparam int N = y * MESH_X + x;

                        router #(
                                .X_POS      (x),
                                .Y_POS      (y),
                                .FIFO_DEPTH (FIFO_DEPTH)
                        ) u_router (
                                .clk       (clk),
                                .arst_n    (arst_n),
                                .in_link   (r_in[N]),
                                .in_ready  (r_in_ready[N]),
                                .out_link  (r_out[N]),
                                .out_ready (r_out_ready[N])
                        );

                        // local injection and ejection
                        assign r_in[N][PORT_LOCAL]        = inj[N];
                        assign inj_ready[N]               = r_in_ready[N][PORT_LOCAL];
                        assign ej[N]                      = r_out[N][PORT_LOCAL];
                        assign r_out_ready[N][PORT_LOCAL] = ej_ready[N];

                        // west neighbour, tied off on column 0
                        if (x > 0) begin : g_west
                                assign r_in[N][PORT_WEST]        = r_out[N-1][PORT_EAST];
                                assign r_out_ready[N][PORT_WEST] = r_in_ready[N-1][PORT_EAST];
                        end else begin : g_west_edge
                                assign r_in[N][PORT_WEST]        = '0;
                                assign r_out_ready[N][PORT_WEST] = 1'b0;
                        end

                        // east neighbour
                        if (x < MESH_X - 1) begin : g_east
                                assign r_in[N][PORT_EAST]        = r_out[N+1][PORT_WEST];
                                assign r_out_ready[N][PORT_EAST] = r_in_ready[N+1][PORT_WEST];
                        end else begin : g_east_edge
                                assign r_in[N][PORT_EAST]        = '0;
                                assign r_out_ready[N][PORT_EAST] = 1'b0;
                        end

                        // north neighbour, row 0 is the top edge
                        if (y > 0) begin : g_north
                                assign r_in[N][PORT_NORTH] = r_out[N-MESH_X][PORT_SOUTH];
                                assign r_out_ready[N][PORT_NORTH] =
                                        r_in_ready[N-MESH_X][PORT_SOUTH];
                        end else begin : g_north_edge
                                assign r_in[N][PORT_NORTH]        = '0;
                                assign r_out_ready[N][PORT_NORTH] = 1'b0;
                        end

                        // south neighbour
                        if (y < MESH_Y - 1) begin : g_south
                                assign r_in[N][PORT_SOUTH] = r_out[N+MESH_X][PORT_NORTH];
                                assign r_out_ready[N][PORT_SOUTH] =
                                        r_in_ready[N+MESH_X][PORT_NORTH];
                        end else begin : g_south_edge
                                assign r_in[N][PORT_SOUTH]        = '0;
                                assign r_out_ready[N][PORT_SOUTH] = 1'b0;
                        end
                end
        end

endmodule

// ==== verification/noc_mesh_assertions.sv ====
`timescale 1ns/1ps

module noc_mesh_assertions
        import noc_pkg::*;
#(
        parameter int MESH_X = 3,
        parameter int MESH_Y = 3
) (
        input logic  clk,
        input logic  arst_n,
        input link_t inj       [MESH_X*MESH_Y],
        input logic  inj_ready [MESH_X*MESH_Y],
        input link_t ej        [MESH_X*MESH_Y],
        input logic  ej_ready  [MESH_X*MESH_Y]
);

        localparam int NODES = MESH_X * MESH_Y;

        // failures so far, read when the run closes
        int unsigned fail_count = 0;

        for (genvar i = 0; i < NODES; i++) begin : g_node
                // this node's place in the grid
                localparam logic [COORD_W-1:0] NODE_X = COORD_W'(i % MESH_X);
                localparam logic [COORD_W-1:0] NODE_Y = COORD_W'(i / MESH_X);

                // nothing ejected in reset
                a_ej_idle_reset: assert property (
                        @(posedge clk) !arst_n |-> !ej[i].valid
                ) else begin
                        fail_count++;
                        $error("ej[%0d] valid while in reset", i);
                end

                // nor in the first cycle after release
                a_ej_idle_release: assert property (
                        @(posedge clk) $rose(arst_n) |-> !ej[i].valid
                ) else begin
                        fail_count++;
                        $error("ej[%0d] valid right after reset release", i);
                end

                // xy routing lands only at the addressed node
                a_ej_dest: assert property (
                        @(posedge clk) disable iff (!arst_n)
                        ej[i].valid |-> (ej[i].flit.dst_x == NODE_X &&
                                         ej[i].flit.dst_y == NODE_Y)
                ) else begin
                        fail_count++;
                        $error("ej[%0d] carries a flit for another node", i);
                end

                // stalled ejection holds
                a_ej_stable: assert property (
                        @(posedge clk) disable iff (!arst_n)
                        (ej[i].valid && !ej_ready[i]) |=> $stable(ej[i])
                ) else begin
                        fail_count++;
                        $error("ej[%0d] changed while stalled", i);
                end

                // injection side protocol
                a_inj_stable: assert property (
                        @(posedge clk) disable iff (!arst_n)
                        (inj[i].valid && !inj_ready[i]) |=>
                                (inj[i].valid && $stable(inj[i].flit))
                ) else begin
                        fail_count++;
                        $error("inj[%0d] dropped or changed while stalled", i);
                end
        end

endmodule

// ==== verification/noc_tb.sv ====
`timescale 1ns/1ps

module noc_tb
        import noc_pkg::*;
();

        localparam int MESH_X        = 3;
        localparam int MESH_Y        = 3;
        localparam int NODES         = MESH_X * MESH_Y;
        localparam int DRAIN_TIMEOUT = 2000;
        localparam int BLOCK_TIMEOUT = 500;
        localparam int RANDOM_ROUNDS = 8;
        localparam int HOTSPOT_FLITS = 8;
        localparam int HOTSPOT_NODE  = 4;

        logic  clk = 1'b0;
        logic  arst_n;
        link_t inj       [NODES];
        logic  inj_ready [NODES];
        link_t ej        [NODES];
        logic  ej_ready  [NODES];

        int seed     = 19;
        int errors   = 0;
        int queued   = 0;
        int injected = 0;
        int ejected  = 0;
        // 0 always ready, 1 random stalls, 2 hotspot node held off
        int ready_mode = 0;

        // pending flits per source with the head on inj
        flit_t       tx_q       [NODES][$];
        // next sequence number per [src][dst]
        int unsigned tx_seq     [NODES][NODES];
        int unsigned rx_seq     [NODES][NODES];
        int          stall_left [NODES];
        logic        fire       [NODES];

        always #4 clk = ~clk;

        noc_mesh #(
                .MESH_X     (MESH_X),
                .MESH_Y     (MESH_Y),
                .FIFO_DEPTH (4)
        ) dut0 (
                .clk       (clk),
                .arst_n    (arst_n),
                .inj       (inj),
                .inj_ready (inj_ready),
                .ej        (ej),
                .ej_ready  (ej_ready)
        );

        bind noc_mesh noc_mesh_assertions #(
                .MESH_X (MESH_X),
                .MESH_Y (MESH_Y)
        ) u_sva (
                .clk       (clk),
                .arst_n    (arst_n),
                .inj       (inj),
                .inj_ready (inj_ready),
                .ej        (ej),
                .ej_ready  (ej_ready)
        );

        // ej_ready for one node in the current mode
        function automatic logic next_ready(input int n);
                if (ready_mode == 2) begin
                        return (n != HOTSPOT_NODE);
                end
                if (ready_mode == 0) begin
                        return 1'b1;
                end
                // stall in progress
                if (stall_left[n] > 0) begin
                        stall_left[n]--;
                        return 1'b0;
                end
                if ($unsigned($random(seed)) % 6 == 0) begin
                        stall_left[n] = 2 + $unsigned($random(seed)) % 10;
                        return 1'b0;
                end
                return 1'b1;
        endfunction

        // payload is the running count for this src/dst pair
        task automatic queue_flit(input int src, input int dst);
                flit_t f;
                f.dst_x   = COORD_W'(dst % MESH_X);
                f.dst_y   = COORD_W'(dst / MESH_X);
                f.src     = NODE_W'(src);
                f.payload = DATA_W'(tx_seq[src][dst]);
                tx_seq[src][dst]++;
                tx_q[src].push_back(f);
                queued++;
        endtask

        task automatic check_ejection(input int dst, input flit_t f);
                int src;
                src = int'(f.src);
                ejected++;
                if (src >= NODES) begin
                        $display("flit ejected at node %0d names unknown source %0d", dst, src);
                        errors++;
                end else begin
                        if (f.payload != DATA_W'(rx_seq[src][dst])) begin
                                $display(
                                        "MISMATCH ej[%0d].flit.payload src %0d: expected %h, got %h",
                                        dst, src, DATA_W'(rx_seq[src][dst]), f.payload);
                                errors++;
                        end
                        // resync so one gap is reported once
                        rx_seq[src][dst] = int'(f.payload) + 1;
                end
        endtask

        // until every queued flit has come out
        task automatic wait_drain(input string what);
                int cyc;
                cyc = 0;
                while (ejected != queued && cyc < DRAIN_TIMEOUT) begin
                        @(posedge clk);
                        cyc++;
                end
                if (ejected != queued) begin
                        $display("timeout in %s: %0d of %0d flits delivered", what, ejected, queued);
                        errors++;
                end
        endtask

        // until back-pressure reaches some source
        task automatic wait_inj_blocked();
                int   cyc;
                logic blocked;
                cyc     = 0;
                blocked = 1'b0;
                while (!blocked && cyc < BLOCK_TIMEOUT) begin
                        @(negedge clk);
                        cyc++;
                        for (int n = 0; n < NODES; n++) begin
                                if (!inj_ready[n]) begin
                                        blocked = 1'b1;
                                end
                        end
                end
                if (!blocked) begin
                        $display("timeout: no inj_ready dropped while node %0d was held off",
                                 HOTSPOT_NODE);
                        errors++;
                end
        endtask

        // source side driver updating 1 ns after the edge
        initial begin
                for (int n = 0; n < NODES; n++) begin
                        inj[n]      = '0;
                        ej_ready[n] = 1'b1;
                end
                forever begin
                        // handshakes completing on the coming edge
                        @(negedge clk);
                        for (int n = 0; n < NODES; n++) begin
                                fire[n] = inj[n].valid && inj_ready[n];
                        end
                        @(posedge clk);
                        #1;
                        for (int n = 0; n < NODES; n++) begin
                                if (fire[n]) begin
                                        void'(tx_q[n].pop_front());
                                        injected++;
                                end
                                // head held until accepted
                                if (tx_q[n].size() > 0) begin
                                        inj[n] = '{valid: 1'b1, flit: tx_q[n][0]};
                                end else begin
                                        inj[n] = '0;
                                end
                                ej_ready[n] = next_ready(n);
                        end
                end
        end

        // ejection monitor samples mid cycle where outputs are settled
        always @(negedge clk) begin
                for (int n = 0; n < NODES; n++) begin
                        if (arst_n && ej[n].valid && ej_ready[n]) begin
                                check_ejection(n, ej[n].flit);
                        end
                end
        end

        initial begin
                // clean falling edge on reset
                arst_n = 1'b1;
                #1;
                arst_n = 1'b0;
                repeat (10) @(posedge clk);
                #1;
                arst_n = 1'b1;

                // empty fifos let every source inject
                @(negedge clk);
                for (int n = 0; n < NODES; n++) begin
                        if (inj_ready[n] !== 1'b1) begin
                                $display("MISMATCH inj_ready[%0d]: expected %h, got %h",
                                         n, 1'b1, inj_ready[n]);
                                errors++;
                        end
                end
                @(posedge clk);

                // every node to every node, self included
                for (int s = 0; s < NODES; s++) begin
                        for (int d = 0; d < NODES; d++) begin
                                queue_flit(s, d);
                        end
                end
                wait_drain("all-to-all phase");

                // random destinations under random stalls
                ready_mode = 1;
                for (int r = 0; r < RANDOM_ROUNDS; r++) begin
                        for (int s = 0; s < NODES; s++) begin
                                queue_flit(s, $unsigned($random(seed)) % NODES);
                        end
                end
                wait_drain("random traffic phase");

                // hotspot held off until sources back up
                ready_mode = 2;
                for (int s = 0; s < NODES; s++) begin
                        for (int k = 0; k < HOTSPOT_FLITS; k++) begin
                                queue_flit(s, HOTSPOT_NODE);
                        end
                end
                wait_inj_blocked();
                @(posedge clk);
                ready_mode = 0;
                wait_drain("hotspot phase");

                // any duplicate shows up during the idle stretch
                repeat (20) @(posedge clk);
                if (injected != queued) begin
                        $display("only %0d of %0d queued flits were injected", injected, queued);
                        errors++;
                end
                if (ejected != injected) begin
                        $display("flit count off after idle: %0d ejected, %0d injected",
                                 ejected, injected);
                        errors++;
                end

                $display("errors: testbench %0d, assertions %0d", errors, dut0.u_sva.fail_count);
                if (errors == 0 && dut0.u_sva.fail_count == 0) begin
                        $display("Result: PASSED");
                end else begin
                        $display("Result: FAILED");
                end
                $finish;
        end

endmodule

// ==== list.f ====
design/noc_pkg.sv
design/input_port.sv
design/port_arbiter.sv
design/router.sv
design/noc_mesh.sv
verification/noc_mesh_assertions.sv
verification/noc_tb.sv

// ==== Bender.yml ====
package:
  name: noc_mesh

sources:
  # rtl, package first
  - design/noc_pkg.sv
  - design/input_port.sv
  - design/port_arbiter.sv
  - design/router.sv
  - design/noc_mesh.sv

  # testbench and bound assertions
  - target: test
    files:
      - verification/noc_mesh_assertions.sv
      - verification/noc_tb.sv
